//--- design/priv_types_pkg.sv
package priv_types_pkg;

  localparam int CSR_XLEN   = 32;            // Machine word
  localparam int CSR_ADDR_W = 12;
  localparam int COUNTER_W  = 2 * CSR_XLEN;  // Full cycle and instret width
  localparam int HART_IDX_W = 4;             // Wide enough to carry a bad index
  localparam int INST_RET_W = 2;             // Up to two retirements per cycle

  typedef logic [CSR_XLEN-1:0]   csr_word_t;
  typedef logic [CSR_ADDR_W-1:0] csr_addr_t;

  // Only user and machine mode exist here
  typedef enum logic [1:0] {
    U_MODE = 2'd0,
    M_MODE = 2'd3
  } priv_level_t;

  typedef enum logic [1:0] {
    CSR_READ  = 2'd0,
    CSR_WRITE = 2'd1,
    CSR_SET   = 2'd2,
    CSR_CLEAR = 2'd3
  } csr_op_t;

endpackage

//--- design/csr_map_pkg.sv
package csr_map_pkg;

  import priv_types_pkg::*;

  // Trap setup
  localparam csr_addr_t MSTATUS_ADDR       = 12'h300;
  localparam csr_addr_t MISA_ADDR          = 12'h301;
  localparam csr_addr_t MIE_ADDR           = 12'h304;
  localparam csr_addr_t MTVEC_ADDR         = 12'h305;
  localparam csr_addr_t MCOUNTEREN_ADDR    = 12'h306;
  localparam csr_addr_t MSTATUSH_ADDR      = 12'h310;
  localparam csr_addr_t MCOUNTINHIBIT_ADDR = 12'h320;
  // Trap handling
  localparam csr_addr_t MSCRATCH_ADDR      = 12'h340;
  localparam csr_addr_t MEPC_ADDR          = 12'h341;
  localparam csr_addr_t MCAUSE_ADDR        = 12'h342;
  localparam csr_addr_t MTVAL_ADDR         = 12'h343;
  localparam csr_addr_t MIP_ADDR           = 12'h344;
  // Counters
  localparam csr_addr_t MCYCLE_ADDR        = 12'hB00;
  localparam csr_addr_t MINSTRET_ADDR      = 12'hB02;
  localparam csr_addr_t MCYCLEH_ADDR       = 12'hB80;
  localparam csr_addr_t MINSTRETH_ADDR     = 12'hB82;
  // Read-only information
  localparam csr_addr_t MVENDORID_ADDR     = 12'hF11;
  localparam csr_addr_t MARCHID_ADDR       = 12'hF12;
  localparam csr_addr_t MIMPID_ADDR        = 12'hF13;
  localparam csr_addr_t MHARTID_ADDR       = 12'hF14;
  localparam csr_addr_t MCONFIGPTR_ADDR    = 12'hF15;

  typedef enum logic [1:0] {
    DIRECT   = 2'd0,
    VECTORED = 2'd1
  } vector_mode_t;

  typedef struct packed {
    logic [18:0] reserved_31_13;  // No S-mode, FS, VS or XS state
    priv_level_t mpp;
    logic [2:0]  reserved_10_8;
    logic        mpie;
    logic [2:0]  reserved_6_4;
    logic        mie;
    logic [2:0]  reserved_2_0;
  } mstatus_t;

  typedef struct packed {
    logic [19:0] reserved_31_12;
    logic        meie;
    logic [2:0]  reserved_10_8;
    logic        mtie;
    logic [2:0]  reserved_6_4;
    logic        msie;
    logic [2:0]  reserved_2_0;
  } mie_t;

  typedef struct packed {
    logic [19:0] reserved_31_12;
    logic        meip;
    logic [2:0]  reserved_10_8;
    logic        mtip;
    logic [2:0]  reserved_6_4;
    logic        msip;
    logic [2:0]  reserved_2_0;
  } mip_t;

  typedef struct packed {
    logic [29:0]  base;
    vector_mode_t mode;
  } mtvec_t;

  typedef struct packed {
    logic        interrupt;
    logic [30:0] code;
  } mcause_t;

  // Shared by mcounteren and mcountinhibit
  typedef struct packed {
    logic [28:0] reserved_31_3;
    logic        ir;
    logic        tm;
    logic        cy;
  } mcounter_ctl_t;

  localparam logic [1:0]  MISA_MXL_32 = 2'd1;
  localparam logic [25:0] MISA_EXT_I  = 26'h000_0100;
  localparam logic [25:0] MISA_EXT_M  = 26'h000_1000;
  localparam logic [25:0] MISA_EXT_U  = 26'h010_0000;
  localparam csr_word_t   MISA_VALUE  = {MISA_MXL_32, 4'b0000,
                                         MISA_EXT_I | MISA_EXT_M | MISA_EXT_U};

  localparam mstatus_t      MSTATUS_RESET       = '{mpp: M_MODE, default: '0};
  localparam mtvec_t        MTVEC_RESET         = '{base: '0, mode: DIRECT};
  localparam mcounter_ctl_t MCOUNTEREN_RESET    = '{cy: 1'b1, tm: 1'b1, ir: 1'b1,
                                                    default: '0};
  localparam mcounter_ctl_t MCOUNTINHIBIT_RESET = '0;

endpackage

//--- design/csr_request_router.sv
`timescale 1ns/100ps

module csr_request_router #(
  parameter int N_HARTS = 4
) (
  input  logic                                  CLK,
  input  logic                                  nRST,
  input  logic                                  req,
  input  logic [priv_types_pkg::HART_IDX_W-1:0] req_hart,
  input  priv_types_pkg::csr_addr_t             req_addr,
  input  priv_types_pkg::csr_op_t               req_op,
  input  priv_types_pkg::csr_word_t             req_wdata,
  input  priv_types_pkg::priv_level_t           req_priv,
  output logic [N_HARTS-1:0]                    hart_access,
  output priv_types_pkg::csr_addr_t             acc_addr,
  output priv_types_pkg::csr_op_t               acc_op,
  output priv_types_pkg::csr_word_t             acc_wdata,
  output priv_types_pkg::priv_level_t           acc_priv,
  output logic                                  acc_valid,
  output logic [priv_types_pkg::HART_IDX_W-1:0] acc_hart,
  output logic                                  acc_bad_hart
);

  logic [N_HARTS-1:0] access_next;
  logic               bad_hart;

  // One-hot decode where an out-of-range index matches no hart
  always_comb begin
    bad_hart = req && (req_hart >= N_HARTS);
    for (int h = 0; h < N_HARTS; h++) begin
      access_next[h] = req && (req_hart == h);
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      hart_access  <= '0;
      acc_valid    <= 1'b0;
      acc_bad_hart <= 1'b0;
    end else begin
      hart_access  <= access_next;
      acc_valid    <= req;
      acc_bad_hart <= bad_hart;
    end
  end

  // Shared bus to all CSR files
  always_ff @(posedge CLK) begin
    if (req) begin
      acc_addr  <= req_addr;
      acc_op    <= req_op;
      acc_wdata <= req_wdata;
      acc_priv  <= req_priv;
      acc_hart  <= req_hart;
    end
  end

  a_access_onehot: assert property (@(posedge CLK) disable iff (!nRST)
    $onehot0(hart_access) && (acc_bad_hart -> (hart_access == '0)));

endmodule

//--- design/machine_csr_file.sv
`timescale 1ns/100ps

module machine_csr_file #(
  parameter int HARTID = 0
) (
  input  logic                                  CLK,
  input  logic                                  nRST,
  input  logic                                  access,
  input  priv_types_pkg::csr_addr_t             addr,
  input  priv_types_pkg::csr_op_t               op,
  input  priv_types_pkg::csr_word_t             wdata,
  input  priv_types_pkg::priv_level_t           priv,
  input  logic [priv_types_pkg::INST_RET_W-1:0] inst_ret,
  input  logic                                  trap,
  input  priv_types_pkg::csr_word_t             trap_cause,
  input  priv_types_pkg::csr_word_t             trap_epc,
  input  priv_types_pkg::csr_word_t             trap_tval,
  input  priv_types_pkg::priv_level_t           cur_priv,
  input  logic                                  irq_timer,
  input  logic                                  irq_ext,
  output priv_types_pkg::csr_word_t             rdata,
  output logic                                  invalid,
  output logic                                  irq_pending,
  output priv_types_pkg::csr_word_t             trap_vector
);

  import priv_types_pkg::*;
  import csr_map_pkg::*;

  mstatus_t               mstatus, mstatus_next;
  mie_t                   mie, mie_next;
  mip_t                   mip;
  logic                   msip, msip_next;  // Only software-writable mip bit
  mtvec_t                 mtvec, mtvec_next;
  csr_word_t              mscratch, mscratch_next;
  csr_word_t              mepc, mepc_next;
  mcause_t                mcause, mcause_next;
  csr_word_t              mtval, mtval_next;
  mcounter_ctl_t          mcounteren, mcounteren_next;
  mcounter_ctl_t          mcountinhibit, mcountinhibit_next;
  logic [COUNTER_W-1:0]   cycle_cnt, cycle_next;
  logic [COUNTER_W-1:0]   instret_cnt, instret_next;
  csr_word_t              old_val;
  csr_word_t              new_val;
  logic                   known;
  logic                   write_op;
  logic                   do_write;

  assign mip = '{msip: msip, mtip: irq_timer, meip: irq_ext, default: '0};

  // Old value of the addressed CSR
  always_comb begin
    known   = 1'b1;
    old_val = '0;
    case (addr)
      MSTATUS_ADDR:       old_val = mstatus;
      MISA_ADDR:          old_val = MISA_VALUE;
      MIE_ADDR:           old_val = mie;
      MTVEC_ADDR:         old_val = mtvec;
      MCOUNTEREN_ADDR:    old_val = mcounteren;
      MSTATUSH_ADDR:      old_val = '0;  // Little-endian only
      MCOUNTINHIBIT_ADDR: old_val = mcountinhibit;
      MSCRATCH_ADDR:      old_val = mscratch;
      MEPC_ADDR:          old_val = mepc;
      MCAUSE_ADDR:        old_val = mcause;
      MTVAL_ADDR:         old_val = mtval;
      MIP_ADDR:           old_val = mip;
      MCYCLE_ADDR:        old_val = cycle_cnt[CSR_XLEN-1:0];
      MCYCLEH_ADDR:       old_val = cycle_cnt[COUNTER_W-1:CSR_XLEN];
      MINSTRET_ADDR:      old_val = instret_cnt[CSR_XLEN-1:0];
      MINSTRETH_ADDR:     old_val = instret_cnt[COUNTER_W-1:CSR_XLEN];
      MVENDORID_ADDR, MARCHID_ADDR, MIMPID_ADDR, MCONFIGPTR_ADDR: old_val = '0;
      MHARTID_ADDR:       old_val = csr_word_t'(HARTID);
      default:            known = 1'b0;
    endcase
  end

  always_comb begin
    case (op)
      CSR_WRITE: new_val = wdata;
      CSR_SET:   new_val = old_val | wdata;
      CSR_CLEAR: new_val = old_val & ~wdata;
      default:   new_val = old_val;
    endcase
  end

  // Unknown address, machine CSR from U-mode, or write to a read-only number
  assign write_op = (op != CSR_READ);
  assign invalid  = access && (!known || (addr[9:8] == 2'b11 && priv == U_MODE) ||
                               (write_op && addr[11:10] == 2'b11));
  assign do_write = access && write_op && !invalid;

  always_comb begin
    mstatus_next       = mstatus;
    mie_next           = mie;
    msip_next          = msip;
    mtvec_next         = mtvec;
    mscratch_next      = mscratch;
    mepc_next          = mepc;
    mcause_next        = mcause;
    mtval_next         = mtval;
    mcounteren_next    = mcounteren;
    mcountinhibit_next = mcountinhibit;
    cycle_next         = cycle_cnt;
    instret_next       = instret_cnt;

    if (!mcountinhibit.cy) cycle_next = cycle_cnt + 1'b1;
    if (!mcountinhibit.ir) instret_next = instret_cnt + inst_ret;

    if (do_write) begin
      case (addr)
        MSTATUS_ADDR: begin
          mstatus_next.mie  = new_val[3];
          mstatus_next.mpie = new_val[7];
          // WARL mpp where the missing modes 1 and 2 fall back to U
          mstatus_next.mpp  = (new_val[12:11] == 2'b11) ? M_MODE : U_MODE;
        end
        MTVEC_ADDR: begin
          mtvec_next.base = new_val[31:2];
          mtvec_next.mode = (new_val[1:0] > 2'd1) ? DIRECT : vector_mode_t'(new_val[1:0]);
        end
        MIE_ADDR: begin
          mie_next.msie = new_val[3];
          mie_next.mtie = new_val[7];
          mie_next.meie = new_val[11];
        end
        MIP_ADDR:           msip_next = new_val[3];  // mtip and meip are wired
        MSCRATCH_ADDR:      mscratch_next = new_val;
        MEPC_ADDR:          mepc_next = new_val;
        MCAUSE_ADDR:        mcause_next = mcause_t'(new_val);
        MTVAL_ADDR:         mtval_next = new_val;
        MCOUNTEREN_ADDR:    mcounteren_next = '{cy: new_val[0], tm: new_val[1],
                                                ir: new_val[2], default: '0};
        MCOUNTINHIBIT_ADDR: mcountinhibit_next = '{cy: new_val[0], ir: new_val[2],
                                                   default: '0};
        MCYCLE_ADDR:        cycle_next[CSR_XLEN-1:0] = new_val;
        MCYCLEH_ADDR:       cycle_next[COUNTER_W-1:CSR_XLEN] = new_val;
        MINSTRET_ADDR:      instret_next[CSR_XLEN-1:0] = new_val;
        MINSTRETH_ADDR:     instret_next[COUNTER_W-1:CSR_XLEN] = new_val;
        default: ;  // misa, mstatush and info registers ignore writes
      endcase
    end

    // Trap entry overrides a CSR write in the same cycle
    if (trap) begin
      mepc_next         = trap_epc;
      mcause_next       = mcause_t'(trap_cause);
      mtval_next        = trap_tval;
      mstatus_next.mpie = mstatus.mie;
      mstatus_next.mie  = 1'b0;
      mstatus_next.mpp  = cur_priv;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mstatus       <= MSTATUS_RESET;
      mie           <= '0;
      msip          <= 1'b0;
      mtvec         <= MTVEC_RESET;
      mscratch      <= '0;
      mepc          <= '0;
      mcause        <= '0;
      mtval         <= '0;
      mcounteren    <= MCOUNTEREN_RESET;
      mcountinhibit <= MCOUNTINHIBIT_RESET;
      cycle_cnt     <= '0;
      instret_cnt   <= '0;
    end else begin
      mstatus       <= mstatus_next;
      mie           <= mie_next;
      msip          <= msip_next;
      mtvec         <= mtvec_next;
      mscratch      <= mscratch_next;
      mepc          <= mepc_next;
      mcause        <= mcause_next;
      mtval         <= mtval_next;
      mcounteren    <= mcounteren_next;
      mcountinhibit <= mcountinhibit_next;
      cycle_cnt     <= cycle_next;
      instret_cnt   <= instret_next;
    end
  end

  assign rdata       = old_val;
  assign irq_pending = mstatus.mie && |(mie & mip);
  assign trap_vector = {mtvec.base, 2'b00};

  // A rejected access leaves every CSR alone while a trap may still move its own registers
  a_invalid_no_write: assert property (@(posedge CLK) disable iff (!nRST)
    invalid |=> $stable({mscratch, mtvec, mie, msip, mcounteren, mcountinhibit}) &&
                ($past(trap) || $stable({mstatus, mepc, mcause, mtval})));

endmodule

//--- design/csr_response_mux.sv
`timescale 1ns/100ps

module csr_response_mux #(
  parameter int N_HARTS = 4
) (
  input  logic                                  CLK,
  input  logic                                  nRST,
  input  logic                                  acc_valid,
  input  logic [priv_types_pkg::HART_IDX_W-1:0] acc_hart,
  input  logic                                  acc_bad_hart,
  input  priv_types_pkg::csr_word_t             hart_rdata [N_HARTS],
  input  logic [N_HARTS-1:0]                    hart_invalid,
  output logic                                  rsp_valid,
  output priv_types_pkg::csr_word_t             rsp_rdata,
  output logic                                  rsp_error
);

  import priv_types_pkg::*;

  csr_word_t sel_rdata;
  logic      sel_error;

  // Bad hart index answers with an error and zero data
  always_comb begin
    sel_rdata = '0;
    sel_error = acc_bad_hart;
    if (!acc_bad_hart) begin
      for (int h = 0; h < N_HARTS; h++) begin
        if (acc_hart == h) begin
          sel_rdata = hart_rdata[h];
          sel_error = hart_invalid[h];
        end
      end
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= acc_valid;
    end
  end

  always_ff @(posedge CLK) begin
    if (acc_valid) begin
      rsp_rdata <= sel_rdata;
      rsp_error <= sel_error;
    end
  end

  a_rsp_follows_acc: assert property (@(posedge CLK) disable iff (!nRST)
    rsp_valid == $past(acc_valid));

endmodule

//--- design/priv_csr_cluster.sv
`timescale 1ns/100ps

module priv_csr_cluster #(
  parameter int N_HARTS = 4
) (
  input  logic                                  CLK,
  input  logic                                  nRST,
  // Request port
  input  logic                                  req,
  input  logic [priv_types_pkg::HART_IDX_W-1:0] req_hart,
  input  priv_types_pkg::csr_addr_t             req_addr,
  input  priv_types_pkg::csr_op_t               req_op,
  input  priv_types_pkg::csr_word_t             req_wdata,
  input  priv_types_pkg::priv_level_t           req_priv,
  // Response port
  output logic                                  rsp_valid,
  output priv_types_pkg::csr_word_t             rsp_rdata,
  output logic                                  rsp_error,
  // Per-hart side ports
  input  logic [priv_types_pkg::INST_RET_W-1:0] inst_ret [N_HARTS],
  input  logic [N_HARTS-1:0]                    trap,
  input  priv_types_pkg::csr_word_t             trap_cause [N_HARTS],
  input  priv_types_pkg::csr_word_t             trap_epc [N_HARTS],
  input  priv_types_pkg::csr_word_t             trap_tval [N_HARTS],
  input  priv_types_pkg::priv_level_t           cur_priv [N_HARTS],
  input  logic [N_HARTS-1:0]                    irq_timer,
  input  logic [N_HARTS-1:0]                    irq_ext,
  output logic [N_HARTS-1:0]                    irq_pending,
  output priv_types_pkg::csr_word_t             trap_vector [N_HARTS]
);

  import priv_types_pkg::*;

  logic [N_HARTS-1:0]    hart_access;
  csr_addr_t             acc_addr;
  csr_op_t               acc_op;
  csr_word_t             acc_wdata;
  priv_level_t           acc_priv;
  logic                  acc_valid;
  logic [HART_IDX_W-1:0] acc_hart;
  logic                  acc_bad_hart;
  csr_word_t             hart_rdata [N_HARTS];
  logic [N_HARTS-1:0]    hart_invalid;

  csr_request_router #(.N_HARTS(N_HARTS)) router_i (
    .CLK, .nRST,
    .req, .req_hart, .req_addr, .req_op, .req_wdata, .req_priv,
    .hart_access, .acc_addr, .acc_op, .acc_wdata, .acc_priv,
    .acc_valid, .acc_hart, .acc_bad_hart
  );

  for (genvar h = 0; h < N_HARTS; h++) begin : g_hart
    machine_csr_file #(.HARTID(h)) csr_file_i (
      .CLK, .nRST,
      .access      (hart_access[h]),
      .addr        (acc_addr),
      .op          (acc_op),
      .wdata       (acc_wdata),
      .priv        (acc_priv),
      .inst_ret    (inst_ret[h]),
      .trap        (trap[h]),
      .trap_cause  (trap_cause[h]),
      .trap_epc    (trap_epc[h]),
      .trap_tval   (trap_tval[h]),
      .cur_priv    (cur_priv[h]),
      .irq_timer   (irq_timer[h]),
      .irq_ext     (irq_ext[h]),
      .rdata       (hart_rdata[h]),
      .invalid     (hart_invalid[h]),
      .irq_pending (irq_pending[h]),
      .trap_vector (trap_vector[h])
    );
  end

  csr_response_mux #(.N_HARTS(N_HARTS)) rsp_mux_i (
    .CLK, .nRST,
    .acc_valid, .acc_hart, .acc_bad_hart, .hart_rdata, .hart_invalid,
    .rsp_valid, .rsp_rdata, .rsp_error
  );

endmodule

//--- test/tb_priv_csr_cluster.sv
`timescale 1ns/100ps

module tb_priv_csr_cluster;

  import priv_types_pkg::*;
  import csr_map_pkg::*;

  localparam int N_HARTS  = 4;
  localparam int WAIT_MAX = 20;  // Cycles before a wait gives up

  logic                  CLK;
  logic                  nRST;
  logic                  req;
  logic [HART_IDX_W-1:0] req_hart;
  csr_addr_t             req_addr;
  csr_op_t               req_op;
  csr_word_t             req_wdata;
  priv_level_t           req_priv;
  logic                  rsp_valid;
  csr_word_t             rsp_rdata;
  logic                  rsp_error;
  logic [INST_RET_W-1:0] inst_ret [N_HARTS];
  logic [N_HARTS-1:0]    trap;
  csr_word_t             trap_cause [N_HARTS];
  csr_word_t             trap_epc [N_HARTS];
  csr_word_t             trap_tval [N_HARTS];
  priv_level_t           cur_priv [N_HARTS];
  logic [N_HARTS-1:0]    irq_timer;
  logic [N_HARTS-1:0]    irq_ext;
  logic [N_HARTS-1:0]    irq_pending;
  csr_word_t             trap_vector [N_HARTS];

  logic [31:0] lcg_state;
  csr_word_t   scratch_model [N_HARTS];  // Expected mscratch per hart
  int          n_checks;
  int          n_errors;
  int          n_timeouts;

  priv_csr_cluster #(.N_HARTS(N_HARTS)) priv_csr_cluster_i (.*);

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    n_errors++;
    $display("error at %0t: %s expected %h, got %h", $time, name, exp, act);
  endtask

  // Issue one request and wait for its response at the falling edge
  task automatic csr_access(
    input  logic [HART_IDX_W-1:0] hart,
    input  csr_addr_t             addr,
    input  csr_op_t               op,
    input  csr_word_t             wdata,
    input  priv_level_t           priv,
    output csr_word_t             rdata,
    output logic                  err
  );
    int waited;
    @(posedge CLK);
    req       <= 1'b1;
    req_hart  <= hart;
    req_addr  <= addr;
    req_op    <= op;
    req_wdata <= wdata;
    req_priv  <= priv;
    @(posedge CLK);
    req <= 1'b0;
    waited = 1;
    @(negedge CLK);
    while (!rsp_valid && waited < WAIT_MAX) begin
      @(negedge CLK);
      waited++;
    end
    rdata = rsp_rdata;
    err   = rsp_error;
    if (!rsp_valid) begin
      n_timeouts++;
      $display("timeout: no response to the request for address %h", addr);
    end else if (waited != 2) begin
      n_errors++;
      $display("response for address %h came after %0d cycles, not 2", addr, waited);
    end
  endtask

  task automatic access_expect(input logic [HART_IDX_W-1:0] hart, input csr_addr_t addr,
                               input csr_op_t op, input csr_word_t wdata,
                               input csr_word_t exp_rdata, input string name);
    csr_word_t rdata;
    logic      err;
    csr_access(hart, addr, op, wdata, M_MODE, rdata, err);
    n_checks += 2;
    if (rdata !== exp_rdata) report_mismatch(name, exp_rdata, rdata);
    if (err !== 1'b0) report_mismatch("rsp_error", 32'd0, 32'(err));
  endtask

  // Rejected access with data checked only where it must read as zero
  task automatic error_expect(input logic [HART_IDX_W-1:0] hart, input csr_addr_t addr,
                              input csr_op_t op, input csr_word_t wdata,
                              input priv_level_t priv, input logic zero_data,
                              input string name);
    csr_word_t rdata;
    logic      err;
    csr_access(hart, addr, op, wdata, priv, rdata, err);
    n_checks += 2;
    if (err !== 1'b1) report_mismatch({name, " rsp_error"}, 32'd1, 32'(err));
    if (zero_data && rdata !== '0) report_mismatch({name, " rsp_rdata"}, '0, rdata);
  endtask

  task automatic read_csr(input logic [HART_IDX_W-1:0] hart, input csr_addr_t addr,
                          output csr_word_t value);
    logic err;
    csr_access(hart, addr, CSR_READ, '0, M_MODE, value, err);
    n_checks++;
    if (err !== 1'b0) report_mismatch("rsp_error", 32'd0, 32'(err));
  endtask

  task automatic reset_values();
    for (int h = 0; h < N_HARTS; h++) begin
      access_expect(HART_IDX_W'(h), MHARTID_ADDR, CSR_READ, '0, csr_word_t'(h), "mhartid");
      access_expect(HART_IDX_W'(h), MISA_ADDR, CSR_READ, '0, MISA_VALUE, "misa");
      // Only mpp at bits 12:11 is set
      access_expect(HART_IDX_W'(h), MSTATUS_ADDR, CSR_READ, '0, 32'h0000_1800, "mstatus");
      access_expect(HART_IDX_W'(h), MTVEC_ADDR, CSR_READ, '0, '0, "mtvec");
      scratch_model[h] = '0;
    end
  endtask

  task automatic write_set_clear();
    csr_word_t value;
    csr_word_t mask;
    for (int h = 0; h < N_HARTS; h++) begin
      value = lcg_next();
      access_expect(HART_IDX_W'(h), MSCRATCH_ADDR, CSR_WRITE, value, scratch_model[h],
                    "mscratch");
      scratch_model[h] = value;
      mask = lcg_next();
      access_expect(HART_IDX_W'(h), MSCRATCH_ADDR, CSR_SET, mask, scratch_model[h],
                    "mscratch");
      scratch_model[h] = scratch_model[h] | mask;
      mask = lcg_next();
      access_expect(HART_IDX_W'(h), MSCRATCH_ADDR, CSR_CLEAR, mask, scratch_model[h],
                    "mscratch");
      scratch_model[h] = scratch_model[h] & ~mask;
    end
    for (int h = 0; h < N_HARTS; h++) begin  // Each hart kept its own value
      access_expect(HART_IDX_W'(h), MSCRATCH_ADDR, CSR_READ, '0, scratch_model[h],
                    "mscratch");
    end
  endtask

  task automatic warl_and_errors();
    // mpp of 2 is not a mode of this core
    access_expect(1, MSTATUS_ADDR, CSR_WRITE, 32'h0000_1000, 32'h0000_1800, "mstatus");
    access_expect(1, MSTATUS_ADDR, CSR_READ, '0, 32'h0000_0000, "mstatus");
    access_expect(1, MTVEC_ADDR, CSR_WRITE, 32'h0000_4003, '0, "mtvec");
    access_expect(1, MTVEC_ADDR, CSR_READ, '0, 32'h0000_4000, "mtvec");
    error_expect(1, MSCRATCH_ADDR, CSR_READ, '0, U_MODE, 1'b0, "user mscratch read");
    error_expect(1, MSCRATCH_ADDR, CSR_WRITE, lcg_next(), U_MODE, 1'b0, "user mscratch write");
    error_expect(1, MVENDORID_ADDR, CSR_WRITE, 32'hffff_ffff, M_MODE, 1'b1, "mvendorid");
    access_expect(1, MVENDORID_ADDR, CSR_READ, '0, '0, "mvendorid");
    error_expect(1, 12'h3A0, CSR_WRITE, lcg_next(), M_MODE, 1'b1, "unknown csr");
    error_expect(5, MSCRATCH_ADDR, CSR_WRITE, lcg_next(), M_MODE, 1'b1, "hart 5");
    for (int h = 0; h < N_HARTS; h++) begin
      access_expect(HART_IDX_W'(h), MSCRATCH_ADDR, CSR_READ, '0, scratch_model[h],
                    "mscratch");
    end
  endtask

  task automatic trap_entry();
    csr_word_t base;
    csr_word_t cause;
    csr_word_t epc;
    csr_word_t tval;
    base  = lcg_next() & 32'hffff_fffc;
    cause = lcg_next();
    epc   = lcg_next();
    tval  = lcg_next();
    access_expect(2, MTVEC_ADDR, CSR_WRITE, base | 32'h1, '0, "mtvec");  // Vectored
    access_expect(2, MSTATUS_ADDR, CSR_SET, 32'h0000_0008, 32'h0000_1800, "mstatus");
    @(posedge CLK);
    trap[2]       <= 1'b1;
    trap_cause[2] <= cause;
    trap_epc[2]   <= epc;
    trap_tval[2]  <= tval;
    cur_priv[2]   <= U_MODE;
    @(posedge CLK);
    trap[2]     <= 1'b0;
    cur_priv[2] <= M_MODE;
    access_expect(2, MEPC_ADDR, CSR_READ, '0, epc, "mepc");
    access_expect(2, MCAUSE_ADDR, CSR_READ, '0, cause, "mcause");
    access_expect(2, MTVAL_ADDR, CSR_READ, '0, tval, "mtval");
    // mie 0, mpie 1, mpp back to user
    access_expect(2, MSTATUS_ADDR, CSR_READ, '0, 32'h0000_0080, "mstatus");
    n_checks++;
    if (trap_vector[2] !== base) report_mismatch("trap_vector[2]", base, trap_vector[2]);
  endtask

  task automatic interrupt_pending();
    access_expect(3, MIE_ADDR, CSR_SET, 32'h0000_0080, '0, "mie");
    access_expect(3, MSTATUS_ADDR, CSR_SET, 32'h0000_0008, 32'h0000_1800, "mstatus");
    @(posedge CLK);
    irq_timer[3] <= 1'b1;
    @(negedge CLK);
    n_checks++;
    if (irq_pending !== 4'b1000) report_mismatch("irq_pending", 32'h8, 32'(irq_pending));
    access_expect(3, MIP_ADDR, CSR_READ, '0, 32'h0000_0080, "mip");
    access_expect(3, MSTATUS_ADDR, CSR_CLEAR, 32'h0000_0008, 32'h0000_1808, "mstatus");
    n_checks++;
    if (irq_pending !== 4'b0000) report_mismatch("irq_pending", 32'h0, 32'(irq_pending));
    @(posedge CLK);
    irq_timer[3] <= 1'b0;
  endtask

  task automatic counters();
    csr_word_t first;
    csr_word_t second;
    int        ret_count;
    read_csr(0, MCYCLE_ADDR, first);
    repeat (5) @(posedge CLK);
    read_csr(0, MCYCLE_ADDR, second);
    n_checks++;
    if (second <= first) begin
      n_errors++;
      $display("error at %0t: mcycle expected above %h, got %h", $time, first, second);
    end
    access_expect(0, MCOUNTINHIBIT_ADDR, CSR_SET, 32'h1, '0, "mcountinhibit");
    read_csr(0, MCYCLE_ADDR, first);
    repeat (5) @(posedge CLK);
    read_csr(0, MCYCLE_ADDR, second);
    n_checks++;
    if (second !== first) report_mismatch("mcycle", first, second);
    access_expect(0, MCOUNTINHIBIT_ADDR, CSR_CLEAR, 32'h1, 32'h1, "mcountinhibit");
    ret_count = 3 + int'(lcg_next() % 32'd8);
    read_csr(0, MINSTRET_ADDR, first);
    @(posedge CLK);
    inst_ret[0] <= 2'd1;
    repeat (ret_count) @(posedge CLK);
    inst_ret[0] <= 2'd0;
    read_csr(0, MINSTRET_ADDR, second);
    n_checks++;
    if (second !== first + ret_count) report_mismatch("minstret", first + ret_count, second);
  endtask

  // Four requests on consecutive cycles where the second reads the first one's write
  task automatic back_to_back();
    logic [HART_IDX_W-1:0] harts [4];
    csr_addr_t             addrs [4];
    csr_op_t               ops [4];
    csr_word_t             wdatas [4];
    csr_word_t             expected [4];
    int                    got;
    int                    cycle;
    harts[0]    = 0;
    addrs[0]    = MSCRATCH_ADDR;
    ops[0]      = CSR_WRITE;
    wdatas[0]   = lcg_next();
    expected[0] = scratch_model[0];
    scratch_model[0] = wdatas[0];
    harts[1]    = 0;
    addrs[1]    = MSCRATCH_ADDR;
    ops[1]      = CSR_READ;
    wdatas[1]   = '0;
    expected[1] = wdatas[0];
    harts[2]    = 3;
    addrs[2]    = MHARTID_ADDR;
    ops[2]      = CSR_READ;
    wdatas[2]   = '0;
    expected[2] = 32'd3;
    harts[3]    = 1;
    addrs[3]    = MSCRATCH_ADDR;
    ops[3]      = CSR_SET;
    wdatas[3]   = lcg_next();
    expected[3] = scratch_model[1];
    scratch_model[1] = scratch_model[1] | wdatas[3];
    got   = 0;
    cycle = 0;
    while (got < 4 && cycle < WAIT_MAX) begin
      @(posedge CLK);
      if (cycle < 4) begin
        req       <= 1'b1;
        req_hart  <= harts[cycle];
        req_addr  <= addrs[cycle];
        req_op    <= ops[cycle];
        req_wdata <= wdatas[cycle];
        req_priv  <= M_MODE;
      end else begin
        req <= 1'b0;
      end
      @(negedge CLK);
      if (rsp_valid) begin
        n_checks += 3;
        if (cycle != got + 2) begin
          n_errors++;
          $display("response %0d came in cycle %0d instead of %0d", got, cycle, got + 2);
        end
        if (rsp_rdata !== expected[got]) report_mismatch("rsp_rdata", expected[got], rsp_rdata);
        if (rsp_error !== 1'b0) report_mismatch("rsp_error", 32'd0, 32'(rsp_error));
        got++;
      end
      cycle++;
    end
    if (got < 4) begin
      n_timeouts++;
      $display("timeout: only %0d of 4 back-to-back responses arrived", got);
    end
    access_expect(1, MSCRATCH_ADDR, CSR_READ, '0, scratch_model[1], "mscratch");
  endtask

  initial begin
    lcg_state  = 32'hbc39;
    n_checks   = 0;
    n_errors   = 0;
    n_timeouts = 0;
    nRST       = 1'b0;
    req        = 1'b0;
    req_hart   = '0;
    req_addr   = '0;
    req_op     = CSR_READ;
    req_wdata  = '0;
    req_priv   = M_MODE;
    trap       = '0;
    irq_timer  = '0;
    irq_ext    = '0;
    for (int h = 0; h < N_HARTS; h++) begin
      inst_ret[h]   = '0;
      trap_cause[h] = '0;
      trap_epc[h]   = '0;
      trap_tval[h]  = '0;
      cur_priv[h]   = M_MODE;
      scratch_model[h] = '0;
    end
    repeat (16) @(posedge CLK);
    nRST <= 1'b1;

    reset_values();
    write_set_clear();
    warl_and_errors();
    trap_entry();
    interrupt_pending();
    counters();
    back_to_back();

    $display("checks: %0d, errors: %0d, timeouts: %0d", n_checks, n_errors, n_timeouts);
    if (n_errors == 0 && n_timeouts == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- project.f
design/priv_types_pkg.sv
design/csr_map_pkg.sv
design/csr_request_router.sv
design/machine_csr_file.sv
design/csr_response_mux.sv
design/priv_csr_cluster.sv
test/tb_priv_csr_cluster.sv

//--- Bender.yml
package:
  name: priv_csr_cluster

sources:
  - design/priv_types_pkg.sv
  - design/csr_map_pkg.sv
  - design/csr_request_router.sv
  - design/machine_csr_file.sv
  - design/csr_response_mux.sv
  - design/priv_csr_cluster.sv
  - target: test
    files:
      - test/tb_priv_csr_cluster.sv
